// ==== verilog/cpuPkg.sv ====
//####################################################################
// Shared widths, types and encodings for the pipelined MIPS-like core
// Imported by every stage module and by the testbench
//####################################################################

package cpuPkg;

  localparam int wordWidth    = 32;  // Data and address width
  localparam int regAddrWidth = 5;   // 32 architectural registers

  typedef logic [wordWidth-1:0]    word_t;
  typedef logic [regAddrWidth-1:0] regAddr_t;

  // Instruction opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_NOP  = 6'b000000,
    OP_ADD  = 6'b000001,
    OP_SUB  = 6'b000011,
    OP_AND  = 6'b000101,
    OP_OR   = 6'b000110,
    OP_NOR  = 6'b000111,
    OP_XOR  = 6'b001000,
    OP_SLL  = 6'b001010,
    OP_SRA  = 6'b001011,
    OP_SRL  = 6'b001100,
    OP_ADDI = 6'b100000,  // Immediate forms
    OP_SUBI = 6'b100001,
    OP_LD   = 6'b100100,  // Memory
    OP_ST   = 6'b100101,
    OP_BEZ  = 6'b101000,  // Branches
    OP_BNE  = 6'b101001,
    OP_JMP  = 6'b101010
  } opcode_e;

  // ALU commands carried into execute
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b0010,
    ALU_AND  = 4'b0100,
    ALU_OR   = 4'b0101,
    ALU_NOR  = 4'b0110,
    ALU_XOR  = 4'b0111,
    ALU_SLL  = 4'b1000,
    ALU_SRA  = 4'b1001,
    ALU_SRL  = 4'b1010,
    ALU_NONE = 4'b1111   // NOP and branches
  } aluCmd_e;

  typedef enum logic [1:0] {
    BR_NONE = 2'b00,
    BR_BNE  = 2'b01,
    BR_JUMP = 2'b10,
    BR_BEZ  = 2'b11
  } branch_e;

  // Operand source in execute
  typedef enum logic [1:0] {
    FWD_REGVAL  = 2'd0,
    FWD_FROMMEM = 2'd1,
    FWD_FROMWB  = 2'd2
  } fwdSel_e;

endpackage

// ==== verilog/fetchStage.sv ====
//####################################################################
// Fetch stage: program counter, next-address select and the
// fetch/decode register; instruction memory sits outside the core
//####################################################################
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  stall,
  input  logic  branchTaken,
  input  word_t branchTarget,
  input  word_t fetchInstr,
  output word_t fetchAddr,
  output word_t idInstr,
  output logic  idValid
);

  word_t nextPc;

  // Taken branch wins over sequential fetch
  assign nextPc = branchTaken ? branchTarget : fetchAddr + 32'd4;

  // PC and valid flag, both frozen on a stall
  always_ff @(posedge clk) begin
    if (rst) begin
      fetchAddr <= '0;
      idValid   <= 1'b0;
    end else if (!stall) begin
      fetchAddr <= nextPc;
      idValid   <= !branchTaken;  // Flushed slot becomes a bubble
    end
  end

  // Instruction word only matters while idValid is set
  always_ff @(posedge clk) begin
    if (!stall) begin
      idInstr <= fetchInstr;
    end
  end

endmodule

// ==== verilog/regFile.sv ====
//####################################################################
// 32-entry register file, two read ports and one write port
// Reads of the register being written return the new value
//####################################################################
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  regAddr_t rdAddr1,
  input  regAddr_t rdAddr2,
  input  logic     wrEn,
  input  regAddr_t wrAddr,
  input  word_t    wrData,
  output word_t    rdData1,
  output word_t    rdData2
);

  localparam int numRegs = 2 ** regAddrWidth;

  word_t regs [numRegs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && wrAddr != '0) begin
      regs[wrAddr] <= wrData;
    end
  end

  // r0 is hardwired to zero, write-through otherwise
  assign rdData1 = (rdAddr1 == '0) ? '0 :
                   (wrEn && wrAddr == rdAddr1) ? wrData : regs[rdAddr1];
  assign rdData2 = (rdAddr2 == '0) ? '0 :
                   (wrEn && wrAddr == rdAddr2) ? wrData : regs[rdAddr2];

endmodule

// ==== verilog/decodeStage.sv ====
//####################################################################
// Decode stage: opcode decode, operand select, branch resolution and
// the decode/execute register; a stall loads a bubble into execute
//####################################################################
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  word_t    idInstr,
  input  logic     idValid,
  input  logic     stall,
  input  word_t    fetchAddr,     // Address of the instruction after this one
  input  word_t    rdData1,
  input  word_t    rdData2,
  output regAddr_t rdAddr1,
  output regAddr_t rdAddr2,
  output logic     branchTaken,
  output word_t    branchTarget,
  output regAddr_t idSrc1,
  output regAddr_t idSrc2,
  output logic     idUsesSrc2,
  output logic     idIsBranch,
  output aluCmd_e  exAluCmd,
  output word_t    exVal1,
  output word_t    exVal2,
  output word_t    exStoreVal,
  output regAddr_t exSrc1,
  output regAddr_t exSrc2,
  output regAddr_t exDest,
  output logic     exWbEn,
  output logic     exMemRead,
  output logic     exMemWrite
);

  opcode_e  opcode;
  regAddr_t fDest;
  regAddr_t fSrc1;
  regAddr_t fSrc2;
  word_t    immExt;
  aluCmd_e  aluCmd;
  branch_e  brKind;
  logic     isRType;
  logic     isImm;
  logic     readsDest;
  logic     usesSrc1;
  logic     wbEn;
  logic     condMet;

  // A bubble decodes as NOP
  assign opcode = idValid ? opcode_e'(idInstr[31:26]) : OP_NOP;
  assign fDest  = idInstr[25:21];
  assign fSrc1  = idInstr[20:16];
  assign fSrc2  = idInstr[15:11];
  assign immExt = {{16{idInstr[15]}}, idInstr[15:0]};

  //##################################################################
  // Control decode
  //##################################################################
  always_comb begin
    aluCmd = ALU_NONE;
    brKind = BR_NONE;
    case (opcode)
      OP_ADD, OP_ADDI, OP_LD, OP_ST: aluCmd = ALU_ADD;  // Address calc uses ADD
      OP_SUB, OP_SUBI: aluCmd = ALU_SUB;
      OP_AND:  aluCmd = ALU_AND;
      OP_OR:   aluCmd = ALU_OR;
      OP_NOR:  aluCmd = ALU_NOR;
      OP_XOR:  aluCmd = ALU_XOR;
      OP_SLL:  aluCmd = ALU_SLL;
      OP_SRA:  aluCmd = ALU_SRA;
      OP_SRL:  aluCmd = ALU_SRL;
      OP_BEZ:  brKind = BR_BEZ;
      OP_BNE:  brKind = BR_BNE;
      OP_JMP:  brKind = BR_JUMP;
      default: ;
    endcase
  end

  assign isRType   = opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_NOR,
                                    OP_XOR, OP_SLL, OP_SRA, OP_SRL};
  assign isImm     = opcode inside {OP_ADDI, OP_SUBI, OP_LD, OP_ST};
  assign readsDest = opcode inside {OP_ST, OP_BNE};  // Dest field is a source here
  assign wbEn      = isRType || opcode inside {OP_ADDI, OP_SUBI, OP_LD};
  assign usesSrc1  = isRType || isImm || brKind inside {BR_BEZ, BR_BNE};

  // Register file addresses
  assign rdAddr1 = fSrc1;
  assign rdAddr2 = readsDest ? fDest : fSrc2;

  // Sources seen by the hazard unit, r0 when unused
  assign idSrc1     = usesSrc1 ? fSrc1 : '0;
  assign idSrc2     = rdAddr2;
  assign idUsesSrc2 = isRType || readsDest;
  assign idIsBranch = brKind inside {BR_BEZ, BR_BNE};

  //##################################################################
  // Branch resolution
  //##################################################################
  always_comb begin
    case (brKind)
      BR_JUMP: condMet = 1'b1;
      BR_BEZ:  condMet = (rdData1 == '0);
      BR_BNE:  condMet = (rdData1 != rdData2);
      default: condMet = 1'b0;
    endcase
  end

  assign branchTaken  = condMet && !stall;  // Operands not ready while stalled
  assign branchTarget = fetchAddr + (immExt << 2);

  //##################################################################
  // Decode/execute register
  //##################################################################
  always_ff @(posedge clk) begin
    if (rst || stall) begin
      exAluCmd   <= ALU_NONE;  // Bubble
      exWbEn     <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
    end else begin
      exAluCmd   <= aluCmd;
      exWbEn     <= wbEn;
      exMemRead  <= (opcode == OP_LD);
      exMemWrite <= (opcode == OP_ST);
    end
  end

  always_ff @(posedge clk) begin
    exVal1     <= rdData1;
    exVal2     <= isImm ? immExt : rdData2;
    exStoreVal <= rdData2;
    exSrc1     <= idSrc1;
    exSrc2     <= isRType ? fSrc2 : '0;  // Keeps the immediate from being overridden
    exDest     <= fDest;
  end

endmodule

// ==== verilog/hazardUnit.sv ====
//####################################################################
// Hazard unit: decode stall for load-use and branch operands, and the
// forwarding selects for the three execute operands
//####################################################################
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
  input  regAddr_t idSrc1,
  input  regAddr_t idSrc2,
  input  logic     idUsesSrc2,
  input  logic     idIsBranch,
  input  regAddr_t exSrc1,
  input  regAddr_t exSrc2,
  input  regAddr_t exDest,
  input  logic     exWbEn,
  input  logic     exMemRead,
  input  regAddr_t memDest,
  input  logic     memWbEn,
  input  regAddr_t wbDest,
  input  logic     wbEnInt,
  output logic     stall,
  output fwdSel_e  fwdSel1,
  output fwdSel_e  fwdSel2,
  output fwdSel_e  fwdSelStore
);

  logic exHit;
  logic memHit;

  // r0 never produces a dependency
  function automatic logic regHit(regAddr_t src, regAddr_t dst, logic wrEn);
    return wrEn && (src != '0) && (src == dst);
  endfunction

  // Youngest producer first
  function automatic fwdSel_e pickSrc(regAddr_t src, regAddr_t mDest, logic mEn,
                                      regAddr_t wDest, logic wEn);
    if (regHit(src, mDest, mEn)) return FWD_FROMMEM;
    if (regHit(src, wDest, wEn)) return FWD_FROMWB;
    return FWD_REGVAL;
  endfunction

  assign exHit  = regHit(idSrc1, exDest, exWbEn) ||
                  (idUsesSrc2 && regHit(idSrc2, exDest, exWbEn));
  assign memHit = regHit(idSrc1, memDest, memWbEn) ||
                  (idUsesSrc2 && regHit(idSrc2, memDest, memWbEn));

  // Loads need one extra cycle, branches compare in decode without forwarding
  assign stall = (exMemRead && exHit) || (idIsBranch && (exHit || memHit));

  assign fwdSel1     = pickSrc(exSrc1, memDest, memWbEn, wbDest, wbEnInt);
  assign fwdSel2     = pickSrc(exSrc2, memDest, memWbEn, wbDest, wbEnInt);
  assign fwdSelStore = pickSrc(exDest, memDest, memWbEn, wbDest, wbEnInt);  // ST data reg

endmodule

// ==== verilog/executeStage.sv ====
//####################################################################
// Execute stage: operand forwarding, the ALU and the execute/memory
// register
//####################################################################
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  aluCmd_e  exAluCmd,
  input  word_t    exVal1,
  input  word_t    exVal2,
  input  word_t    exStoreVal,
  input  regAddr_t exDest,
  input  logic     exWbEn,
  input  logic     exMemRead,
  input  logic     exMemWrite,
  input  fwdSel_e  fwdSel1,
  input  fwdSel_e  fwdSel2,
  input  fwdSel_e  fwdSelStore,
  input  word_t    wbData,
  output word_t    memAluRes,
  output word_t    memStoreVal,
  output regAddr_t memDest,
  output logic     memWbEn,
  output logic     memRead,
  output logic     memWrite
);

  word_t aluA;
  word_t aluB;
  word_t storeVal;
  word_t aluRes;

  function automatic word_t pickVal(fwdSel_e sel, word_t regVal, word_t memVal,
                                    word_t wbVal);
    case (sel)
      FWD_FROMMEM: return memVal;
      FWD_FROMWB:  return wbVal;
      default:     return regVal;
    endcase
  endfunction

  assign aluA     = pickVal(fwdSel1, exVal1, memAluRes, wbData);
  assign aluB     = pickVal(fwdSel2, exVal2, memAluRes, wbData);
  assign storeVal = pickVal(fwdSelStore, exStoreVal, memAluRes, wbData);

  // Shift amount is the low five bits of the second operand
  always_comb begin
    case (exAluCmd)
      ALU_ADD: aluRes = aluA + aluB;
      ALU_SUB: aluRes = aluA - aluB;
      ALU_AND: aluRes = aluA & aluB;
      ALU_OR:  aluRes = aluA | aluB;
      ALU_NOR: aluRes = ~(aluA | aluB);
      ALU_XOR: aluRes = aluA ^ aluB;
      ALU_SLL: aluRes = aluA << aluB[4:0];
      ALU_SRA: aluRes = word_t'($signed(aluA) >>> aluB[4:0]);  // Sign fill
      ALU_SRL: aluRes = aluA >> aluB[4:0];
      default: aluRes = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memWbEn  <= 1'b0;
      memRead  <= 1'b0;
      memWrite <= 1'b0;
    end else begin
      memWbEn  <= exWbEn;
      memRead  <= exMemRead;
      memWrite <= exMemWrite;
    end
  end

  always_ff @(posedge clk) begin
    memAluRes   <= aluRes;
    memStoreVal <= storeVal;
    memDest     <= exDest;
  end

endmodule

// ==== verilog/memoryStage.sv ====
//####################################################################
// Memory stage: word-addressed data memory and the memory/write-back
// register that drives the core's write-back port
//####################################################################
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; #(
  parameter int dataWords = 256  // Power of two
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    memAluRes,
  input  word_t    memStoreVal,
  input  regAddr_t memDest,
  input  logic     memWbEn,
  input  logic     memRead,
  input  logic     memWrite,
  output logic     wbValid,
  output regAddr_t wbDest,
  output word_t    wbData
);

  localparam int idxWidth = $clog2(dataWords);

  word_t                dataMem [dataWords];
  logic [idxWidth-1:0]  wordIdx;
  word_t                loadVal;

  // Byte address to word index, wraps at dataWords
  assign wordIdx = memAluRes[2 +: idxWidth];
  assign loadVal = dataMem[wordIdx];

  always_ff @(posedge clk) begin
    if (memWrite) begin
      dataMem[wordIdx] <= memStoreVal;
    end
  end

  //##################################################################
  // Memory/write-back register
  //##################################################################
  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= memWbEn && (memDest != '0);  // r0 results are dropped here
    end
  end

  always_ff @(posedge clk) begin
    wbDest <= memDest;
    wbData <= memRead ? loadVal : memAluRes;
  end

endmodule

// ==== verilog/mipsCore.sv ====
//####################################################################
// Five-stage MIPS-like core top level
// Fetch port returns the instruction combinationally in the same cycle;
// every wbValid pulse is one register write
//####################################################################
`timescale 1ns/1ps

module mipsCore import cpuPkg::*; #(
  parameter int dataWords = 256
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    fetchInstr,
  output word_t    fetchAddr,
  output logic     wbValid,
  output regAddr_t wbDest,
  output word_t    wbData
);

  // Fetch and decode
  word_t    idInstr;
  logic     idValid;
  logic     stall;
  logic     branchTaken;
  word_t    branchTarget;
  regAddr_t rdAddr1, rdAddr2;
  word_t    rdData1, rdData2;
  regAddr_t idSrc1, idSrc2;
  logic     idUsesSrc2, idIsBranch;

  // Execute
  aluCmd_e  exAluCmd;
  word_t    exVal1, exVal2, exStoreVal;
  regAddr_t exSrc1, exSrc2, exDest;
  logic     exWbEn, exMemRead, exMemWrite;
  fwdSel_e  fwdSel1, fwdSel2, fwdSelStore;

  // Memory
  word_t    memAluRes, memStoreVal;
  regAddr_t memDest;
  logic     memWbEn, memRead, memWrite;

  fetchStage u_fetch (.*);

  regFile u_regFile (
    .wrEn   (wbValid),
    .wrAddr (wbDest),
    .wrData (wbData),
    .*
  );

  decodeStage u_decode (.*);

  hazardUnit u_hazard (
    .wbEnInt (wbValid),
    .*
  );

  executeStage u_execute (.*);

  memoryStage #(.dataWords(dataWords)) u_memory (.*);

endmodule

// ==== bench/mipsCore_checker.sv ====
//####################################################################
// Protocol assertions on the fetch and write-back ports of the core
// Bound into every mipsCore instance
//####################################################################
`timescale 1ns/1ps

module mipsCore_checker import cpuPkg::*; (
  input logic     clk,
  input logic     rst,
  input word_t    fetchAddr,
  input logic     wbValid,
  input regAddr_t wbDest,
  input logic     stall,
  input logic     branchTaken,
  input word_t    branchTarget
);

  int failCount = 0;  // Failed assertions, read by the testbench

  resetState: assert property (@(posedge clk) rst |=> fetchAddr == '0 && !wbValid)
    else begin
      $error("Reset did not clear fetchAddr and wbValid");
      failCount++;
    end

  pcAligned: assert property (@(posedge clk) disable iff (rst) fetchAddr[1:0] == 2'b00)
    else begin
      $error("Fetch address not word aligned");
      failCount++;
    end

  // Sequential fetch when nothing redirects or holds the PC
  pcSequential: assert property (@(posedge clk) disable iff (rst)
      !rst && !stall && !branchTaken |=> fetchAddr == $past(fetchAddr) + 32'd4)
    else begin
      $error("Fetch address did not advance by 4");
      failCount++;
    end

  pcHeld: assert property (@(posedge clk) disable iff (rst)
      !rst && stall |=> fetchAddr == $past(fetchAddr))
    else begin
      $error("Fetch address moved during a stall");
      failCount++;
    end

  branchFollowed: assert property (@(posedge clk) disable iff (rst)
      !rst && branchTaken |=> fetchAddr == $past(branchTarget))
    else begin
      $error("Fetch address is not the branch target after a taken branch");
      failCount++;
    end

  noR0Write: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbDest != '0)
    else begin
      $error("Write-back pulse with destination r0");
      failCount++;
    end

endmodule

bind mipsCore mipsCore_checker u_checker (
  .clk          (clk),
  .rst          (rst),
  .fetchAddr    (fetchAddr),
  .wbValid      (wbValid),
  .wbDest       (wbDest),
  .stall        (stall),
  .branchTaken  (branchTaken),
  .branchTarget (branchTarget)
);

// ==== bench/mipsCoreTb.sv ====
//####################################################################
// Testbench for the pipelined core: program ROM on the fetch port,
// instruction-level model, and checks on every write-back pulse
//####################################################################
`timescale 1ns/1ps

module mipsCoreTb import cpuPkg::*; ();

  localparam int dataWords = 256;
  localparam int clkPeriod = 100;
  localparam int romWords  = 64;

  logic     clk = 1'b0;
  logic     rst;
  word_t    fetchInstr;
  word_t    fetchAddr;
  logic     wbValid;
  regAddr_t wbDest;
  word_t    wbData;

  word_t       rom [romWords];
  word_t       modelRegs [32];
  word_t       modelMem [dataWords];
  regAddr_t    expDest [$];          // Expected write-backs in order
  word_t       expData [$];
  logic [31:0] rngState = 32'h4182_03fb;
  int          progLen;
  int          modelSteps;
  word_t       endAddr;              // Address of the final self jump

  mipsCore #(.dataWords(dataWords)) u_dut (.*);

  always #(clkPeriod / 2) clk = ~clk;

  // Instruction returned in the same cycle
  assign fetchInstr = rom[fetchAddr[2 +: $clog2(romWords)]];

  //##################################################################
  // Helpers
  //##################################################################
  function automatic logic [31:0] xorshift(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [15:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState[15:0];
  endfunction

  function automatic word_t rInstr(opcode_e op, int d, int s1, int s2);
    return {op, d[4:0], s1[4:0], s2[4:0], 11'b0};
  endfunction

  function automatic word_t iInstr(opcode_e op, int d, int s1, int imm);
    return {op, d[4:0], s1[4:0], imm[15:0]};
  endfunction

  task automatic emit(word_t instr);
    rom[progLen] = instr;
    progLen++;
  endtask

  task automatic stopRun(string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic reportMismatch(string name, word_t expected, word_t actual);
    $display("FAILED at %0t ns: %s expected 0x%08h, got 0x%08h",
             $time, name, expected, actual);
    stopRun("Observed value differs from the expected one");
  endtask

  //##################################################################
  // Program
  //##################################################################
  task automatic buildProgram();
    int loopIdx;
    emit(iInstr(OP_ADDI, 9, 0, 16));
    emit(iInstr(OP_ADDI, 1, 0, nextRandom()));   // Random 32-bit operands
    emit(rInstr(OP_SLL, 1, 1, 9));
    emit(iInstr(OP_ADDI, 2, 0, nextRandom()));
    emit(rInstr(OP_XOR, 1, 1, 2));
    emit(iInstr(OP_ADDI, 3, 0, nextRandom()));
    emit(rInstr(OP_SLL, 3, 3, 9));
    emit(iInstr(OP_ADDI, 2, 0, nextRandom()));
    emit(rInstr(OP_XOR, 3, 3, 2));
    emit(rInstr(OP_ADD, 4, 1, 3));                // Dependent ALU chain
    emit(rInstr(OP_SUB, 5, 4, 1));
    emit(rInstr(OP_AND, 6, 5, 4));
    emit(rInstr(OP_OR, 7, 6, 3));
    emit(rInstr(OP_NOR, 8, 7, 6));
    emit(rInstr(OP_XOR, 10, 8, 7));
    emit(iInstr(OP_ADDI, 11, 0, (nextRandom() & 16'h001f) | 16'h0001));
    emit(rInstr(OP_NOR, 14, 10, 0));              // One of r10, r14 is negative
    emit(rInstr(OP_SRA, 12, 10, 11));
    emit(rInstr(OP_SRA, 13, 14, 11));
    emit(rInstr(OP_SRL, 15, 10, 11));
    emit(rInstr(OP_SRL, 16, 14, 11));
    emit(rInstr(OP_SLL, 17, 13, 11));
    emit(iInstr(OP_ADDI, 18, 17, -5));
    emit(iInstr(OP_SUBI, 19, 18, -300));
    emit(rInstr(OP_ADD, 0, 18, 19));              // Dest r0, no write-back
    emit(rInstr(OP_ADD, 18, 0, 19));
    // Memory traffic
    emit(iInstr(OP_ADDI, 20, 0, 'h40));
    emit(iInstr(OP_ST, 19, 20, 8));
    emit(iInstr(OP_LD, 21, 20, 8));
    emit(rInstr(OP_ADD, 22, 21, 1));              // Load-use
    emit(iInstr(OP_ST, 22, 20, 'h7fc));           // Wraps onto word 15
    emit(iInstr(OP_LD, 23, 20, -4));
    emit(rInstr(OP_SUB, 24, 23, 22));
    // Counted loop, BEZ skips one instruction on the last pass
    emit(iInstr(OP_ADDI, 25, 0, 3));
    loopIdx = progLen;
    emit(rInstr(OP_ADD, 26, 26, 25));
    emit(iInstr(OP_SUBI, 25, 25, 1));
    emit(iInstr(OP_BEZ, 0, 25, 1));
    emit(iInstr(OP_ADDI, 27, 27, 1));
    emit(iInstr(OP_BNE, 0, 25, loopIdx - progLen - 1));
    emit(iInstr(OP_ADDI, 28, 0, nextRandom()));
    emit(iInstr(OP_LD, 29, 20, 8));
    emit(iInstr(OP_ADDI, 30, 29, -1));
    emit(iInstr(OP_JMP, 0, 0, 1));
    emit(iInstr(OP_ADDI, 31, 0, nextRandom()));   // Never executed
    emit(iInstr(OP_JMP, 0, 0, -1));               // Jump to itself
  endtask

  //##################################################################
  // Instruction-level model
  //##################################################################
  task automatic runModel();
    word_t   pc;
    word_t   nextPc;
    word_t   instr;
    word_t   a;
    word_t   b;
    word_t   imm;
    word_t   res;
    opcode_e op;
    int      d;
    int      idx;
    logic    wr;
    logic    done;
    pc = '0;
    done = 1'b0;
    foreach (modelRegs[i]) modelRegs[i] = '0;
    while (!done) begin
      instr  = rom[(pc / 4) % romWords];
      op     = opcode_e'(instr[31:26]);
      d      = instr[25:21];
      a      = modelRegs[instr[20:16]];
      b      = modelRegs[instr[15:11]];
      imm    = {{16{instr[15]}}, instr[15:0]};
      idx    = ((a + imm) / 4) % dataWords;
      nextPc = pc + 4;
      wr     = 1'b1;
      res    = '0;
      case (op)
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_NOR:  res = ~(a | b);
        OP_XOR:  res = a ^ b;
        OP_SLL:  res = a << b[4:0];
        OP_SRL:  res = a >> b[4:0];
        OP_SRA:  res = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
        OP_ADDI: res = a + imm;
        OP_SUBI: res = a - imm;
        OP_LD:   res = modelMem[idx];
        OP_ST: begin
          wr = 1'b0;
          modelMem[idx] = modelRegs[d];   // Dest field holds the data register
        end
        OP_BEZ: begin
          wr = 1'b0;
          if (a == '0) nextPc = pc + 4 + (imm << 2);
        end
        OP_BNE: begin
          wr = 1'b0;
          if (a != modelRegs[d]) nextPc = pc + 4 + (imm << 2);
        end
        OP_JMP: begin
          wr = 1'b0;
          nextPc = pc + 4 + (imm << 2);
          done = (nextPc == pc);
        end
        default: wr = 1'b0;
      endcase
      if (wr && d != 0) begin
        modelRegs[d] = res;
        expDest.push_back(regAddr_t'(d));
        expData.push_back(res);
      end
      pc = nextPc;
      modelSteps++;
      if (modelSteps > 1000) stopRun("Model never reached the final jump");
    end
    endAddr = pc;
  endtask

  //##################################################################
  // Write-back checks
  //##################################################################
  always @(posedge clk) begin
    if (!rst && wbValid) begin
      assert (expDest.size() != 0) else stopRun("Write-back seen after the last expected one");
      assert (wbDest == expDest[0]) else reportMismatch("wbDest", expDest[0], wbDest);
      assert (wbData == expData[0]) else reportMismatch("wbData", expData[0], wbData);
      void'(expDest.pop_front());
      void'(expData.pop_front());
    end
  end

  // Protocol failures from the bound checker end the run at once
  always @(posedge clk) begin
    if (u_dut.u_checker.failCount != 0) begin
      stopRun("A protocol assertion in the bound checker failed");
    end
  end

  // Watchdog, 10 cycles per modelled instruction once reset is released
  initial begin
    @(negedge rst);
    #(modelSteps * 10 * clkPeriod);
    stopRun("Timeout: the core did not reach the final jump in time");
  end

  initial begin
    rst = 1'b1;
    progLen = 0;
    foreach (rom[i]) rom[i] = '0;
    buildProgram();
    runModel();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (fetchAddr == '0) else reportMismatch("fetchAddr", '0, fetchAddr);
    assert (!wbValid) else stopRun("wbValid active right after reset");
    while (expDest.size() != 0 || fetchAddr != endAddr) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);   // Pipeline drain, flushed slots must stay silent
    if (u_dut.u_checker.failCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== src.f ====
verilog/cpuPkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
bench/mipsCore_checker.sv
bench/mipsCoreTb.sv
